// ==== include/cycle_ctrl_settings.svh ====
// Cycle control settings
`ifndef CYCLE_CTRL_SETTINGS_SVH
`define CYCLE_CTRL_SETTINGS_SVH

// Interval and length counter width
`define CTRL_CNT_W 8

// Clocks between refresh requests after reset
`define CTRL_REFRESH_DEFAULT 240

// Memory cycle length in clocks
`define CTRL_MEM_LEN_DEFAULT 6

// IO cycle length, slower than memory
`define CTRL_IO_LEN_DEFAULT 10

`endif

// ==== src/cycle_ctrl_pkg.sv ====
// Cycle control types
`default_nettype none

`include "cycle_ctrl_settings.svh"

package cycle_ctrl_pkg;

  // CPU side request levels
  typedef struct packed {
    logic crq;   // CPU wants the bus
    logic iorq;  // IO cycle, else memory
  } cpu_req_t;

  // DMA and semaphore request levels
  typedef struct packed {
    logic brq;    // DMA or external bus controller
    logic semrq;  // Semaphore, locks the next cycle
  } ext_req_t;

  // Registered grant outputs, one bit each
  typedef struct packed {
    logic cact;   // CPU active on the bus
    logic gnt;    // DMA grant
    logic refg;   // Refresh grant
    logic iod;    // IO cycle, whole cycle long
    logic mem;    // Memory cycle incl. refresh and DMA
    logic sem;    // Semaphore grant
    logic act;    // Bus active
    logic doref;  // Last cycle was a refresh
  } grant_t;

  typedef struct packed {
    logic [`CTRL_CNT_W-1:0] refresh_ival;
    logic [`CTRL_CNT_W-1:0] mem_len;
    logic [`CTRL_CNT_W-1:0] io_len;
  } cycle_cfg_t;

  // Config register select
  typedef enum logic [1:0] {
    REG_REFRESH = 2'd0,
    REG_MEM_LEN = 2'd1,
    REG_IO_LEN  = 2'd2
  } cfg_addr_t;

endpackage

`default_nettype wire

// ==== src/req_sync.sv ====
// Request level synchronizer
`timescale 1ns/1ps
`default_nettype none

module req_sync
  import cycle_ctrl_pkg::*;
#(
  parameter type T = cpu_req_t
) (
  input  wire logic CK,
  input  wire logic rst_n,
  input  wire T     d,  // Async levels from the requester
  output T          q   // Synchronized, two clocks later
);

  // First stage may go metastable
  T meta;

  always_ff @(posedge CK or negedge rst_n) begin
    if (!rst_n) begin
      meta <= T'('0);
      q    <= T'('0);
    end else begin
      meta <= d;     // Capture
      q    <= meta;  // Settled copy
    end
  end

endmodule

`default_nettype wire

// ==== src/cycle_cfg_regs.sv ====
// Cycle configuration registers
`timescale 1ns/1ps
`default_nettype none

`include "cycle_ctrl_settings.svh"

module cycle_cfg_regs
  import cycle_ctrl_pkg::*;
(
  input  wire logic                   CK,
  input  wire logic                   rst_n,
  input  wire logic                   cfg_we,     // One-cycle write strobe
  input  wire cfg_addr_t              cfg_addr,
  input  wire logic [`CTRL_CNT_W-1:0] cfg_wdata,
  output cycle_cfg_t                  cfg
);

  logic [`CTRL_CNT_W-1:0] wval;

  // Zero would mean an empty cycle or interval
  assign wval = (cfg_wdata == '0) ? `CTRL_CNT_W'(1) : cfg_wdata;

  always_ff @(posedge CK or negedge rst_n) begin
    if (!rst_n) begin
      cfg.refresh_ival <= `CTRL_CNT_W'(`CTRL_REFRESH_DEFAULT);
      cfg.mem_len      <= `CTRL_CNT_W'(`CTRL_MEM_LEN_DEFAULT);
      cfg.io_len       <= `CTRL_CNT_W'(`CTRL_IO_LEN_DEFAULT);
    end else if (cfg_we) begin
      case (cfg_addr)
        REG_REFRESH: cfg.refresh_ival <= wval;
        REG_MEM_LEN: cfg.mem_len      <= wval;
        REG_IO_LEN:  cfg.io_len       <= wval;
        default: ;  // Unused address, write dropped
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/refresh_timer.sv ====
// Memory refresh interval timer
`timescale 1ns/1ps
`default_nettype none

`include "cycle_ctrl_settings.svh"

module refresh_timer (
  input  wire logic                   CK,
  input  wire logic                   rst_n,
  input  wire logic [`CTRL_CNT_W-1:0] refresh_ival,
  input  wire logic                   refg,         // Refresh granted
  output logic                        refrq
);

  // Down-counter, parked at zero while a request waits
  logic [`CTRL_CNT_W-1:0] cnt;

  always_ff @(posedge CK or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= `CTRL_CNT_W'(`CTRL_REFRESH_DEFAULT);
      refrq <= 1'b0;
    end else if (refg) begin
      // Served, start the next interval
      cnt   <= refresh_ival;
      refrq <= 1'b0;
    end else if (!refrq) begin
      if (cnt > `CTRL_CNT_W'(1)) begin
        cnt <= cnt - 1'b1;
      end else begin
        cnt   <= '0;    // Interval done
        refrq <= 1'b1;  // Held until refg
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/cycle_arbiter.sv ====
// Bus cycle control state logic
`timescale 1ns/1ps
`default_nettype none

module cycle_arbiter
  import cycle_ctrl_pkg::*;
(
  input  wire logic     CK,
  input  wire logic     rst_n,
  input  wire logic     mr,     // Master reset, spares refresh only
  input  wire cpu_req_t cpu,    // Synchronized CPU request
  input  wire ext_req_t ext,    // Synchronized DMA and semaphore requests
  input  wire logic     refrq,
  input  wire logic     bdry,   // Bus cycle ends
  output grant_t        grant
);

  // No grant held, no lock, not at a cycle end
  logic bus_idle;

  // Set terms, numbered by priority
  logic ref_set;        // 1
  logic cpu_after_ref;  // 2
  logic dma_set;        // 3
  logic cpu_set;        // 4

  // Semaphore terms
  logic cpu_sem;
  logic dma_sem;

  logic   cpu_win;
  grant_t nxt;

  always_comb begin
    bus_idle = ~grant.cact & ~grant.gnt & ~grant.refg & ~grant.sem & ~bdry;

    ref_set       = refrq & bus_idle;
    cpu_after_ref = cpu.crq & ~refrq & grant.doref & bus_idle & ~mr;
    // DMA loses to the CPU only right after a refresh
    dma_set       = ext.brq & ~refrq & (~cpu.crq | ~grant.doref) & bus_idle & ~mr;
    cpu_set       = cpu.crq & ~refrq & ~ext.brq & bus_idle & ~mr;

    // Locked cycle goes to the CPU first, DMA only if the CPU is quiet
    cpu_sem = cpu.crq & grant.sem & ~grant.gnt & ~bdry & ~mr;
    dma_sem = ext.brq & grant.sem & ~cpu.crq & ~grant.cact & ~grant.gnt & ~bdry & ~mr;

    cpu_win = cpu_after_ref | cpu_set | cpu_sem;

    nxt.cact = cpu_win
             | (grant.cact & ~bdry & ~mr);  // Hold
    nxt.gnt  = dma_set | dma_sem
             | (grant.gnt & ~bdry & ~mr);   // Hold
    nxt.refg = ref_set
             | (grant.refg & ~bdry)         // Hold, even through mr
             | (refrq & mr);                // Always refresh during mr

    // IO qualifier lasts the whole CPU cycle
    nxt.iod = (cpu_win & cpu.iorq)
            | (grant.iod & ~bdry & ~mr);

    // Memory strobe on refresh, CPU memory and DMA cycles
    nxt.mem = nxt.refg | nxt.gnt | (nxt.cact & ~nxt.iod);

    // Set at a cycle end, cleared as act falls at the end of the locked cycle
    nxt.sem = ~mr & ((ext.semrq & bdry) | (grant.sem & ~(grant.act & bdry)));

    // One clock behind the grant
    nxt.act = (((grant.cact | grant.gnt) & ~mr) | grant.refg) & ~bdry;

    // Kept through the idle gap, dropped once the next owner is in
    nxt.doref = ~mr & ((grant.refg & bdry)
                       | (grant.doref & ~grant.cact & ~grant.gnt & ~grant.refg));
  end

  always_ff @(posedge CK or negedge rst_n) begin
    if (!rst_n) begin
      grant <= '0;
    end else begin
      grant <= nxt;
    end
  end

endmodule

`default_nettype wire

// ==== src/bus_cycle_timer.sv ====
// Bus cycle length timer
`timescale 1ns/1ps
`default_nettype none

`include "cycle_ctrl_settings.svh"

module bus_cycle_timer (
  input  wire logic                   CK,
  input  wire logic                   rst_n,
  input  wire logic                   act,      // Bus active
  input  wire logic                   iod,      // Picks the IO length
  input  wire logic [`CTRL_CNT_W-1:0] mem_len,
  input  wire logic [`CTRL_CNT_W-1:0] io_len,
  output logic                        bdry      // End of cycle pulse
);

  logic [`CTRL_CNT_W-1:0] cnt;
  logic                   busy;  // Length already loaded this cycle
  logic [`CTRL_CNT_W-1:0] len;

  assign len = iod ? io_len : mem_len;

  always_ff @(posedge CK or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
      bdry <= 1'b0;
    end else if (!act) begin
      // Idle between cycles, also after an mr abort
      busy <= 1'b0;
      cnt  <= '0;
      bdry <= 1'b0;
    end else if (!busy) begin
      // First act clock
      busy <= 1'b1;
      cnt  <= len - 1'b1;
      bdry <= (len <= `CTRL_CNT_W'(1));  // Single-clock cycle
    end else begin
      bdry <= (cnt == `CTRL_CNT_W'(1));  // Fires once, then parks at zero
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/cycle_ctrl_top.sv ====
// Bus cycle control top level
`timescale 1ns/1ps
`default_nettype none

`include "cycle_ctrl_settings.svh"

module cycle_ctrl_top
  import cycle_ctrl_pkg::*;
(
  input  wire logic                   CK,
  input  wire logic                   rst_n,
  input  wire logic                   mr,
  input  wire cpu_req_t               cpu,        // Async CPU request
  input  wire ext_req_t               ext,        // Async DMA and semaphore
  input  wire logic                   cfg_we,
  input  wire cfg_addr_t              cfg_addr,
  input  wire logic [`CTRL_CNT_W-1:0] cfg_wdata,
  output grant_t                      grant,
  output logic                        bdry
);

  cpu_req_t   cpu_s;
  ext_req_t   ext_s;
  cycle_cfg_t cfg;
  logic       refrq;

  req_sync #(.T(cpu_req_t)) u_cpu_sync (
    .CK    (CK),
    .rst_n (rst_n),
    .d     (cpu),
    .q     (cpu_s)
  );

  req_sync #(.T(ext_req_t)) u_ext_sync (
    .CK    (CK),
    .rst_n (rst_n),
    .d     (ext),
    .q     (ext_s)
  );

  cycle_cfg_regs u_cfg (
    .CK        (CK),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  refresh_timer u_refresh (
    .CK           (CK),
    .rst_n        (rst_n),
    .refresh_ival (cfg.refresh_ival),
    .refg         (grant.refg),
    .refrq        (refrq)
  );

  cycle_arbiter u_arb (
    .CK    (CK),
    .rst_n (rst_n),
    .mr    (mr),
    .cpu   (cpu_s),
    .ext   (ext_s),
    .refrq (refrq),
    .bdry  (bdry),
    .grant (grant)
  );

  bus_cycle_timer u_timer (
    .CK      (CK),
    .rst_n   (rst_n),
    .act     (grant.act),
    .iod     (grant.iod),
    .mem_len (cfg.mem_len),
    .io_len  (cfg.io_len),
    .bdry    (bdry)
  );

endmodule

`default_nettype wire

// ==== tests/cycle_ctrl_props.sv ====
// Arbiter grant properties
`timescale 1ns/1ps
`default_nettype none

module cycle_ctrl_props
  import cycle_ctrl_pkg::*;
(
  input wire logic   CK,
  input wire logic   rst_n,
  input wire logic   mr,
  input wire logic   bdry,
  input wire grant_t grant
);

  int fail_count = 0;  // Assertion failures so far

  // A single bus owner at a time
  a_one_owner: assert property (@(posedge CK) disable iff (!rst_n)
    $onehot0({grant.cact, grant.gnt, grant.refg}))
    else begin
      fail_count++;
      $error("More than one of cact, gnt and refg high");
    end

  // Owner and IO qualifier held up to bdry
  // Refresh keeps the bus through mr
  a_owner_hold: assert property (@(posedge CK) disable iff (!rst_n)
    (grant.cact || grant.gnt || grant.refg) && !bdry && (!mr || grant.refg)
    |=> $stable({grant.cact, grant.gnt, grant.refg, grant.iod}))
    else begin
      fail_count++;
      $error("Bus owner or IO qualifier changed before bdry");
    end

  // Bus busy, so no fresh owner
  a_no_new_grant: assert property (@(posedge CK) disable iff (!rst_n)
    grant.act |=> !($rose(grant.cact) || $rose(grant.gnt) || $rose(grant.refg)))
    else begin
      fail_count++;
      $error("New grant issued while act high");
    end

endmodule

bind cycle_arbiter cycle_ctrl_props u_props (
  .CK    (CK),
  .rst_n (rst_n),
  .mr    (mr),
  .bdry  (bdry),
  .grant (grant)
);

`default_nettype wire

// ==== tests/tb_cycle_ctrl.sv ====
// Cycle control testbench
`timescale 1ns/1ps
`default_nettype none

`include "cycle_ctrl_settings.svh"

module tb_cycle_ctrl
  import cycle_ctrl_pkg::*;
();

  localparam int N_TESTS    = 6;
  localparam int BUS_CYCLES = 8;    // Bus cycles per test, upper bound
  localparam int MAX_LEN    = 16;   // Longest cycle length used, plus slack
  localparam int WAIT_LIMIT = 300;  // One full refresh interval and then some
  localparam int WD_CYCLES  = N_TESTS * (BUS_CYCLES * (MAX_LEN + 4) + 256) + 200;

  logic                   CK;
  logic                   rst_n;
  logic                   mr;
  cpu_req_t               cpu;
  ext_req_t               ext;
  logic                   cfg_we;
  cfg_addr_t              cfg_addr;
  logic [`CTRL_CNT_W-1:0] cfg_wdata;
  grant_t                 grant;
  logic                   bdry;

  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;
  logic [31:0] lfsr   = 32'h6738_d5aa;

  cycle_ctrl_top uut (
    .CK        (CK),
    .rst_n     (rst_n),
    .mr        (mr),
    .cpu       (cpu),
    .ext       (ext),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .grant     (grant),
    .bdry      (bdry)
  );

  initial begin
    CK = 1'b0;
    forever #10 CK = ~CK;
  end

  // Hang guard
  initial begin
    repeat (WD_CYCLES) @(posedge CK);
    $display("Watchdog expired after %0d cycles, run stopped", WD_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic check_grant(input grant_t exp, input string what);
    checks++;
    if (grant !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, grant %b expected %b", $time, what, grant, exp);
    end
  endtask

  task automatic check_bdry(input logic exp, input string what);
    checks++;
    if (bdry !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, bdry %b expected %b", $time, what, bdry, exp);
    end
  endtask

  // Galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic rand_len(output int len);
    int v;
    v = 0;
    repeat (3) begin
      v    = (v << 1) | lfsr[0];  // One step per bit
      lfsr = lfsr_step(lfsr);
    end
    len = 3 + v;  // 3 to 10 clocks
  endtask

  task automatic write_cfg(input cfg_addr_t a, input int v);
    @(posedge CK);
    cfg_we    <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= v[`CTRL_CNT_W-1:0];
    @(posedge CK);
    cfg_we    <= 1'b0;
  endtask

  // Next owner among cpu, dma and refresh
  task automatic wait_owner(output grant_t g);
    int n;
    n = 0;
    @(negedge CK);
    while (!(grant.cact | grant.gnt | grant.refg) && n < WAIT_LIMIT) begin
      @(negedge CK);
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      errors++;
      $display("No bus grant came within %0d cycles at %0t ns", WAIT_LIMIT, $time);
    end
    g = grant;
  endtask

  task automatic wait_release();
    int n;
    n = 0;
    while ((grant.cact | grant.gnt | grant.refg) && n < WAIT_LIMIT) begin
      @(negedge CK);
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      errors++;
      $display("Bus grant was never released, at %0t ns", $time);
    end
  endtask

  task automatic wait_bdry();
    int n;
    n = 0;
    @(negedge CK);
    while (!bdry && n < WAIT_LIMIT) begin
      @(negedge CK);
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      errors++;
      $display("Bus cycle never ended, at %0t ns", $time);
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("%s: %s", name, (errors == err0) ? "ok" : "errors");
  endtask

  // One CPU cycle on an idle bus, checked clock by clock
  task automatic run_cpu_cycle(input logic io, input int len, input logic doref_in);
    grant_t exp;
    @(posedge CK);
    cpu <= '{crq: 1'b1, iorq: io};
    exp       = '0;
    exp.doref = doref_in;
    repeat (3) begin
      @(negedge CK);
      check_grant(exp, "bus idle while request syncs");
    end
    @(negedge CK);
    exp.cact = 1'b1;
    exp.iod  = io;
    exp.mem  = ~io;   // IO cycles carry no memory strobe
    check_grant(exp, "CPU grant three clocks after request");
    @(posedge CK);
    cpu <= '0;        // Requester saw its grant
    @(negedge CK);
    exp.act   = 1'b1;
    exp.doref = 1'b0;  // New owner clears it
    check_grant(exp, "act one clock after grant");
    repeat (len - 1) begin
      @(negedge CK);
      check_bdry(1'b0, "bdry early");
    end
    @(negedge CK);
    check_bdry(1'b1, "bdry len clocks after act");
    check_grant(exp, "grant held through bdry");
    @(negedge CK);
    check_grant('0, "grant dropped after bdry");
    check_bdry(1'b0, "bdry lasts one clock");
  endtask

  task automatic test_reset_defaults();
    int err0;
    err0 = errors;
    @(negedge CK);
    check_grant('0, "grant after reset");
    check_bdry(1'b0, "bdry after reset");
    run_cpu_cycle(1'b0, `CTRL_MEM_LEN_DEFAULT, 1'b0);
    end_test("reset and defaults", err0);
  endtask

  task automatic test_cpu_cycles();
    int     err0;
    int     mlen;
    int     ilen;
    grant_t exp;
    err0 = errors;
    // Let a refresh go by so the timer reloads the long interval
    write_cfg(REG_REFRESH, 255);
    wait_owner(exp);
    check_grant('{refg: 1'b1, mem: 1'b1, default: 1'b0}, "refresh before CPU cycles");
    wait_release();
    for (int i = 0; i < 2; i++) begin
      rand_len(mlen);
      rand_len(ilen);
      write_cfg(REG_MEM_LEN, mlen);
      write_cfg(REG_IO_LEN, ilen);
      run_cpu_cycle(1'b0, mlen, i == 0);  // Refresh left doref set
      run_cpu_cycle(1'b1, ilen, 1'b0);
    end
    end_test("CPU memory and IO cycles", err0);
  endtask

  task automatic test_priority();
    int     err0;
    grant_t g;
    err0 = errors;
    write_cfg(REG_MEM_LEN, 8);
    write_cfg(REG_REFRESH, 8);  // Short gap, next refresh lands mid CPU cycle
    wait_owner(g);
    check_grant('{refg: 1'b1, mem: 1'b1, default: 1'b0}, "refresh to arm short interval");
    wait_release();
    @(posedge CK);
    cpu <= '{crq: 1'b1, iorq: 1'b0};
    wait_owner(g);
    check_grant('{cact: 1'b1, mem: 1'b1, doref: 1'b1, default: 1'b0}, "CPU after refresh");
    @(posedge CK);
    ext <= '{brq: 1'b1, semrq: 1'b0};  // CPU keeps asking too
    wait_release();
    wait_owner(g);
    check_grant('{refg: 1'b1, mem: 1'b1, default: 1'b0}, "pending refresh first");
    write_cfg(REG_REFRESH, 255);  // Reloaded while refg holds
    wait_release();
    wait_owner(g);
    check_grant('{cact: 1'b1, mem: 1'b1, doref: 1'b1, default: 1'b0}, "CPU beats DMA once");
    @(posedge CK);
    cpu <= '0;
    wait_release();
    wait_owner(g);
    check_grant('{gnt: 1'b1, mem: 1'b1, default: 1'b0}, "DMA after CPU");
    @(posedge CK);
    ext <= '0;
    wait_release();
    // No refresh behind, both at once
    @(posedge CK);
    cpu <= '{crq: 1'b1, iorq: 1'b0};
    ext <= '{brq: 1'b1, semrq: 1'b0};
    wait_owner(g);
    check_grant('{gnt: 1'b1, mem: 1'b1, default: 1'b0}, "DMA beats CPU");
    @(posedge CK);
    ext <= '0;
    wait_release();
    wait_owner(g);
    check_grant('{cact: 1'b1, mem: 1'b1, default: 1'b0}, "CPU after DMA");
    @(posedge CK);
    cpu <= '0;
    wait_release();
    end_test("priority", err0);
  endtask

  task automatic test_refresh_timer();
    int     err0;
    grant_t g;
    err0 = errors;
    write_cfg(REG_REFRESH, 16);
    wait_owner(g);
    check_grant('{refg: 1'b1, mem: 1'b1, default: 1'b0}, "first refresh");
    wait_release();
    for (int i = 0; i < 2; i++) begin
      repeat (16) begin
        @(negedge CK);
        check_grant('{doref: 1'b1, default: 1'b0}, "idle between refreshes");
      end
      @(negedge CK);  // Interval count plus one arbitration clock
      check_grant('{refg: 1'b1, mem: 1'b1, doref: 1'b1, default: 1'b0}, "periodic refresh");
      if (i == 1) begin
        write_cfg(REG_REFRESH, 255);
      end
      wait_release();
    end
    end_test("refresh timer", err0);
  endtask

  task automatic test_master_reset();
    int err0;
    int n;
    err0 = errors;
    @(posedge CK);
    mr  <= 1'b1;
    cpu <= '{crq: 1'b1, iorq: 1'b0};
    ext <= '{brq: 1'b1, semrq: 1'b0};
    n = 0;
    do begin
      @(negedge CK);
      if (grant.cact | grant.gnt) begin
        errors++;
        $display("CPU or DMA was granted while mr was high, at %0t ns", $time);
      end
      n++;
    end while (!grant.refg && n < WAIT_LIMIT);
    check_grant('{refg: 1'b1, mem: 1'b1, default: 1'b0}, "refresh granted under mr");
    wait_release();
    @(posedge CK);
    cpu <= '0;
    ext <= '0;
    repeat (3) @(posedge CK);  // Sync stages empty
    mr <= 1'b0;
    @(negedge CK);
    check_grant('0, "idle after mr");
    end_test("master reset", err0);
  endtask

  task automatic test_semaphore();
    int     err0;
    grant_t g;
    err0 = errors;
    write_cfg(REG_MEM_LEN, 6);
    @(posedge CK);
    cpu <= '{crq: 1'b1, iorq: 1'b0};
    wait_owner(g);
    check_grant('{cact: 1'b1, mem: 1'b1, default: 1'b0}, "CPU cycle before lock");
    @(posedge CK);
    cpu <= '0;
    ext <= '{brq: 1'b0, semrq: 1'b1};  // Lock asked mid cycle
    wait_bdry();
    @(negedge CK);
    check_grant('{sem: 1'b1, default: 1'b0}, "sem set at bdry");
    @(posedge CK);
    ext <= '{brq: 1'b1, semrq: 1'b0};
    cpu <= '{crq: 1'b1, iorq: 1'b0};
    wait_owner(g);
    check_grant('{cact: 1'b1, mem: 1'b1, sem: 1'b1, default: 1'b0}, "CPU wins locked cycle");
    @(posedge CK);
    cpu <= '0;
    wait_bdry();
    @(negedge CK);
    check_grant('0, "sem cleared as act falls");
    wait_owner(g);
    check_grant('{gnt: 1'b1, mem: 1'b1, default: 1'b0}, "DMA after lock");
    @(posedge CK);
    ext <= '0;
    wait_release();
    end_test("semaphore", err0);
  endtask

  initial begin
    rst_n     = 1'b0;
    mr        = 1'b0;
    cpu       = '0;
    ext       = '0;
    cfg_we    = 1'b0;
    cfg_addr  = REG_REFRESH;
    cfg_wdata = '0;
    repeat (4) @(posedge CK);
    rst_n <= 1'b1;
    test_reset_defaults();
    test_cpu_cycles();
    test_priority();
    test_refresh_timer();
    test_master_reset();
    test_semaphore();
    errors += uut.u_arb.u_props.fail_count;  // Bound arbiter assertions
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
src/cycle_ctrl_pkg.sv
src/req_sync.sv
src/cycle_cfg_regs.sv
src/refresh_timer.sv
src/cycle_arbiter.sv
src/bus_cycle_timer.sv
src/cycle_ctrl_top.sv
tests/cycle_ctrl_props.sv
tests/tb_cycle_ctrl.sv

// ==== Bender.yml ====
package:
  name: cycle_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cycle_ctrl_pkg.sv
      - src/req_sync.sv
      - src/cycle_cfg_regs.sv
      - src/refresh_timer.sv
      - src/cycle_arbiter.sv
      - src/bus_cycle_timer.sv
      - src/cycle_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cycle_ctrl_props.sv
      - tests/tb_cycle_ctrl.sv
